//--- verilog/ifu_pkg.sv
// shared constants and types for the instruction fetch unit
// bus and instruction widths, reset pc, nop encoding
// rv32i major opcodes and fetch fsm states
package ifu_pkg;

    parameter int ADDR_WIDTH = 32;                         // instruction address bits
    parameter int DATA_WIDTH = 32;                         // instruction word bits
    parameter int ID_WIDTH   = 4;                          // axi id bits

    parameter logic [ADDR_WIDTH-1:0] RESET_PC = 32'h0000_0000;  // first fetch address
    parameter logic [DATA_WIDTH-1:0] INST_NOP = 32'h0000_0013;  // addi x0,x0,0

    // rv32i major opcodes seen by the predictor
    typedef enum logic [6:0] {
        OPC_JAL    = 7'b1101111,                           // direct jump
        OPC_JALR   = 7'b1100111,                           // register jump, not predicted
        OPC_BRANCH = 7'b1100011                            // conditional branches
    } opcode_e;

    // axi read master fsm
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,                                 // waiting to issue
        FETCH_ADDR = 2'd1,                                 // arvalid up
        FETCH_DATA = 2'd2                                  // rready up
    } fetch_state_e;

endpackage

//--- verilog/ifu_pc_gen.sv
// fetch program counter
// reset value, redirect load, +4 step on address acceptance
`timescale 1ns/100ps

module ifu_pc_gen #(
    parameter logic [ifu_pkg::ADDR_WIDTH-1:0] RESET_PC = ifu_pkg::RESET_PC
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           redirect_i,       // load new flow
    input  logic [ifu_pkg::ADDR_WIDTH-1:0] redirect_addr_i,  // new flow address
    input  logic                           pc_accept_i,      // ar handshake for pc
    output logic [ifu_pkg::ADDR_WIDTH-1:0] pc_o              // next address to fetch
);

    logic [ifu_pkg::ADDR_WIDTH-1:0] pc_q;

    // redirect wins over the sequential step
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_addr_i;                                // jump or prediction
        end else if (pc_accept_i) begin
            pc_q <= pc_q + ifu_pkg::ADDR_WIDTH'(4);                 // next word
        end
    end

    assign pc_o = pc_q;

endmodule

//--- verilog/ifu_axi_master.sv
// single-outstanding axi4 read master for instruction fetch
// one 4-byte incr beat per pc, address tag for the returned word
// stale flag drops responses of abandoned addresses
`timescale 1ns/100ps

module ifu_axi_master #(
    parameter logic [ifu_pkg::ID_WIDTH-1:0] AXI_ID = '0
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic [ifu_pkg::ADDR_WIDTH-1:0] pc_i,           // address to fetch
    input  logic                           hold_i,         // no new request
    input  logic                           redirect_i,     // flow change
    output logic                           pc_accept_o,    // pc taken by the bus
    output logic [ifu_pkg::DATA_WIDTH-1:0] fetch_data_o,
    output logic [ifu_pkg::ADDR_WIDTH-1:0] fetch_addr_o,
    output logic                           fetch_valid_o,  // one-cycle pulse
    output logic                           fetch_err_o,

    output logic [  ifu_pkg::ID_WIDTH-1:0] m_axi_arid_o,
    output logic [ifu_pkg::ADDR_WIDTH-1:0] m_axi_araddr_o,
    output logic [                    7:0] m_axi_arlen_o,
    output logic [                    2:0] m_axi_arsize_o,
    output logic [                    1:0] m_axi_arburst_o,
    output logic                           m_axi_arvalid_o,
    input  logic                           m_axi_arready_i,

    input  logic [  ifu_pkg::ID_WIDTH-1:0] m_axi_rid_i,
    input  logic [ifu_pkg::DATA_WIDTH-1:0] m_axi_rdata_i,
    input  logic [                    1:0] m_axi_rresp_i,
    input  logic                           m_axi_rlast_i,
    input  logic                           m_axi_rvalid_i,
    output logic                           m_axi_rready_o
);

    ifu_pkg::fetch_state_e          state_q;
    logic [ifu_pkg::ADDR_WIDTH-1:0] req_addr_q;      // address of the read in flight
    logic                           stale_q;         // response no longer wanted
    logic                           issue;
    logic                           ar_hs;
    logic                           r_done;

    assign issue  = (state_q == ifu_pkg::FETCH_IDLE) && !hold_i && !redirect_i;
    assign ar_hs  = m_axi_arvalid_o && m_axi_arready_i;
    assign r_done = m_axi_rready_o && m_axi_rvalid_i && m_axi_rlast_i;  // last beat taken

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ifu_pkg::FETCH_IDLE;
            stale_q <= 1'b0;
        end else begin
            case (state_q)
                ifu_pkg::FETCH_IDLE: if (issue) state_q <= ifu_pkg::FETCH_ADDR;
                ifu_pkg::FETCH_ADDR: if (ar_hs) state_q <= ifu_pkg::FETCH_DATA;
                ifu_pkg::FETCH_DATA: if (r_done) state_q <= ifu_pkg::FETCH_IDLE;
                default:             state_q <= ifu_pkg::FETCH_IDLE;
            endcase
            if (r_done) begin
                stale_q <= 1'b0;                               // read retired
            end else if (redirect_i && state_q != ifu_pkg::FETCH_IDLE) begin
                stale_q <= 1'b1;                               // read already committed
            end
        end
    end

    // address is frozen until arready
    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr_q <= pc_i;
        end
    end

    // an abandoned address does not step pc past the new target
    assign pc_accept_o = ar_hs && !stale_q;

    assign m_axi_arid_o    = AXI_ID;
    assign m_axi_araddr_o  = req_addr_q;
    assign m_axi_arlen_o   = 8'd0;                             // single beat
    assign m_axi_arsize_o  = 3'b010;                           // 4 bytes
    assign m_axi_arburst_o = 2'b01;                            // incr
    assign m_axi_arvalid_o = (state_q == ifu_pkg::FETCH_ADDR);
    assign m_axi_rready_o  = (state_q == ifu_pkg::FETCH_DATA);

    // same-cycle pass-through of the beat, foreign ids are swallowed
    assign fetch_valid_o = r_done && !stale_q && !redirect_i && (m_axi_rid_i == AXI_ID);
    assign fetch_data_o  = m_axi_rdata_i;
    assign fetch_addr_o  = req_addr_q;
    assign fetch_err_o   = m_axi_rresp_i[1];                   // slverr or decerr

endmodule

//--- verilog/ifu_pipe.sv
// if/id stage register
// flush to nop with valid low, hold freezes, else capture fetch
`timescale 1ns/100ps

module ifu_pipe (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic [ifu_pkg::DATA_WIDTH-1:0] fetch_data_i,
    input  logic [ifu_pkg::ADDR_WIDTH-1:0] fetch_addr_i,
    input  logic                           fetch_valid_i,
    input  logic                           fetch_err_i,
    input  logic                           hold_i,             // freeze outputs
    input  logic                           flush_i,            // kill current slot
    output logic [ifu_pkg::DATA_WIDTH-1:0] inst_o,
    output logic [ifu_pkg::ADDR_WIDTH-1:0] inst_addr_o,
    output logic                           inst_valid_o,
    output logic                           read_resp_error_o
);

    logic [ifu_pkg::DATA_WIDTH-1:0] inst_q;
    logic [ifu_pkg::ADDR_WIDTH-1:0] addr_q;
    logic                           valid_q;
    logic                           err_q;
    logic                           load;

    assign load = fetch_valid_i && !hold_i && !flush_i;    // new word enters id

    // flush beats hold
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_q  <= ifu_pkg::INST_NOP;
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else if (flush_i) begin
            inst_q  <= ifu_pkg::INST_NOP;                   // bubble
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else if (!hold_i) begin
            valid_q <= fetch_valid_i;                       // empty cycle clears valid
            err_q   <= fetch_valid_i && fetch_err_i;
            if (fetch_valid_i) begin
                inst_q <= fetch_data_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            addr_q <= fetch_addr_i;
        end
    end

    assign inst_o            = inst_q;
    assign inst_addr_o       = addr_q;
    assign inst_valid_o      = valid_q;
    assign read_resp_error_o = err_q;

endmodule

//--- verilog/ifu_sbpu.sv
// static branch prediction on the id slot
// jal always taken, b-type taken when backward (negative offset)
// target = instruction address + immediate
`timescale 1ns/100ps

module ifu_sbpu (
    input  logic [ifu_pkg::DATA_WIDTH-1:0] inst_i,
    input  logic [ifu_pkg::ADDR_WIDTH-1:0] inst_addr_i,
    input  logic                           inst_valid_i,
    input  logic                           hold_i,
    output logic                           branch_taken_o,    // redirect fetch
    output logic [ifu_pkg::ADDR_WIDTH-1:0] branch_addr_o,     // predicted target
    output logic                           is_pred_branch_o   // slot is a predicted branch
);

    ifu_pkg::opcode_e               opcode;
    logic [ifu_pkg::ADDR_WIDTH-1:0] imm_j;
    logic [ifu_pkg::ADDR_WIDTH-1:0] imm_b;
    logic [ifu_pkg::ADDR_WIDTH-1:0] imm_sel;
    logic                           predict;
    logic                           active;

    assign opcode = ifu_pkg::opcode_e'(inst_i[6:0]);
    assign active = inst_valid_i && !hold_i;               // only a live, moving slot

    // j-type offset, 21 bits sign-extended
    assign imm_j = {{(ifu_pkg::ADDR_WIDTH-21){inst_i[31]}},
                    inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // b-type offset, 13 bits sign-extended
    assign imm_b = {{(ifu_pkg::ADDR_WIDTH-13){inst_i[31]}},
                    inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    always_comb begin
        predict = 1'b0;
        imm_sel = imm_b;
        case (opcode)
            ifu_pkg::OPC_JAL: begin
                predict = 1'b1;                            // unconditional
                imm_sel = imm_j;
            end
            ifu_pkg::OPC_BRANCH: begin
                predict = inst_i[31];                      // btfn: backward taken
            end
            ifu_pkg::OPC_JALR: begin
                predict = 1'b0;                            // target lives in a register
            end
            default: begin
                predict = 1'b0;
            end
        endcase
    end

    assign branch_taken_o   = active && predict;
    assign is_pred_branch_o = active && predict;
    assign branch_addr_o    = inst_addr_i + imm_sel;

endmodule

//--- verilog/ifu.sv
// instruction fetch unit top
// pc generator, axi4 read master, if/id register, static predictor
// merges external and predicted redirects
`timescale 1ns/100ps

module ifu #(
    parameter logic [ifu_pkg::ADDR_WIDTH-1:0] RESET_PC = ifu_pkg::RESET_PC,
    parameter logic [  ifu_pkg::ID_WIDTH-1:0] AXI_ID   = '0
) (
    input  logic                           clk,
    input  logic                           rst_n_i,

    input  logic                           redirect_i,         // from control unit
    input  logic [ifu_pkg::ADDR_WIDTH-1:0] redirect_addr_i,
    input  logic                           hold_i,
    input  logic                           flush_i,

    output logic [ifu_pkg::DATA_WIDTH-1:0] inst_o,             // to decode
    output logic [ifu_pkg::ADDR_WIDTH-1:0] inst_addr_o,
    output logic                           inst_valid_o,
    output logic                           is_pred_branch_o,
    output logic                           read_resp_error_o,

    output logic [  ifu_pkg::ID_WIDTH-1:0] m_axi_arid_o,
    output logic [ifu_pkg::ADDR_WIDTH-1:0] m_axi_araddr_o,
    output logic [                    7:0] m_axi_arlen_o,
    output logic [                    2:0] m_axi_arsize_o,
    output logic [                    1:0] m_axi_arburst_o,
    output logic                           m_axi_arvalid_o,
    input  logic                           m_axi_arready_i,
    input  logic [  ifu_pkg::ID_WIDTH-1:0] m_axi_rid_i,
    input  logic [ifu_pkg::DATA_WIDTH-1:0] m_axi_rdata_i,
    input  logic [                    1:0] m_axi_rresp_i,
    input  logic                           m_axi_rlast_i,
    input  logic                           m_axi_rvalid_i,
    output logic                           m_axi_rready_o
);

    logic                           redirect;
    logic [ifu_pkg::ADDR_WIDTH-1:0] redirect_addr;
    logic                           flush;
    logic                           stall_fetch;
    logic [ifu_pkg::ADDR_WIDTH-1:0] pc;
    logic                           pc_accept;
    logic [ifu_pkg::DATA_WIDTH-1:0] fetch_data;
    logic [ifu_pkg::ADDR_WIDTH-1:0] fetch_addr;
    logic                           fetch_valid;
    logic                           fetch_err;
    logic                           branch_taken;
    logic [ifu_pkg::ADDR_WIDTH-1:0] branch_addr;

    // external jump outranks the prediction
    assign redirect      = redirect_i || branch_taken;
    assign redirect_addr = redirect_i ? redirect_addr_i : branch_addr;
    assign flush         = flush_i || redirect;              // drop the wrong-path slot
    assign stall_fetch   = hold_i;

    ifu_pc_gen #(
        .RESET_PC(RESET_PC)
    ) u_pc_gen (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .redirect_i     (redirect),
        .redirect_addr_i(redirect_addr),
        .pc_accept_i    (pc_accept),
        .pc_o           (pc)
    );

    ifu_axi_master #(
        .AXI_ID(AXI_ID)
    ) u_axi_master (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pc_i           (pc),
        .hold_i         (stall_fetch),
        .redirect_i     (redirect),
        .pc_accept_o    (pc_accept),
        .fetch_data_o   (fetch_data),
        .fetch_addr_o   (fetch_addr),
        .fetch_valid_o  (fetch_valid),
        .fetch_err_o    (fetch_err),
        .m_axi_arid_o   (m_axi_arid_o),
        .m_axi_araddr_o (m_axi_araddr_o),
        .m_axi_arlen_o  (m_axi_arlen_o),
        .m_axi_arsize_o (m_axi_arsize_o),
        .m_axi_arburst_o(m_axi_arburst_o),
        .m_axi_arvalid_o(m_axi_arvalid_o),
        .m_axi_arready_i(m_axi_arready_i),
        .m_axi_rid_i    (m_axi_rid_i),
        .m_axi_rdata_i  (m_axi_rdata_i),
        .m_axi_rresp_i  (m_axi_rresp_i),
        .m_axi_rlast_i  (m_axi_rlast_i),
        .m_axi_rvalid_i (m_axi_rvalid_i),
        .m_axi_rready_o (m_axi_rready_o)
    );

    ifu_pipe u_pipe (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .fetch_data_i     (fetch_data),
        .fetch_addr_i     (fetch_addr),
        .fetch_valid_i    (fetch_valid),
        .fetch_err_i      (fetch_err),
        .hold_i           (hold_i),
        .flush_i          (flush),
        .inst_o           (inst_o),
        .inst_addr_o      (inst_addr_o),
        .inst_valid_o     (inst_valid_o),
        .read_resp_error_o(read_resp_error_o)
    );

    // predictor looks at the id slot
    ifu_sbpu u_sbpu (
        .inst_i          (inst_o),
        .inst_addr_i     (inst_addr_o),
        .inst_valid_i    (inst_valid_o),
        .hold_i          (hold_i),
        .branch_taken_o  (branch_taken),
        .branch_addr_o   (branch_addr),
        .is_pred_branch_o(is_pred_branch_o)
    );

endmodule

//--- test/tb_ifu.sv
// testbench for the instruction fetch unit
// clock, reset, random program image, axi read responder with random delays
// next-address model, random redirect and hold stimulus, checks
`timescale 1ns/100ps

module tb_ifu;

    localparam int NUM_DELIVER = 300;                   // deliveries to check
    localparam int TIMEOUT     = 200;                   // cycles without a delivery

    logic        clk;
    logic        rst_n_i;
    logic        redirect_i;
    logic [31:0] redirect_addr_i;
    logic        hold_i;
    logic        flush_i;
    logic [31:0] inst_o;
    logic [31:0] inst_addr_o;
    logic        inst_valid_o;
    logic        is_pred_branch_o;
    logic        read_resp_error_o;
    logic [3:0]  m_axi_arid_o;
    logic [31:0] m_axi_araddr_o;
    logic [7:0]  m_axi_arlen_o;
    logic [2:0]  m_axi_arsize_o;
    logic [1:0]  m_axi_arburst_o;
    logic        m_axi_arvalid_o;
    logic        m_axi_arready_i;
    logic [3:0]  m_axi_rid_i;
    logic [31:0] m_axi_rdata_i;
    logic [1:0]  m_axi_rresp_i;
    logic        m_axi_rlast_i;
    logic        m_axi_rvalid_i;
    logic        m_axi_rready_o;

    logic [31:0] prog [256];                            // instruction image
    logic [31:0] step [256];                            // byte distance to next delivery
    logic        pred [256];                            // jal or backward branch
    logic        err  [256];                            // word answers slverr

    ifu u_dut (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #50 clk = ~clk;                         // 100 ns period
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] jal_word(input logic [31:0] o);
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, ifu_pkg::OPC_JAL};   // rd = x1
    endfunction

    // regs holds rs2, rs1 and funct3
    function automatic logic [31:0] branch_word(input logic [31:0] o, input logic [12:0] regs);
        return {o[12], o[10:5], regs, o[4:1], o[11], ifu_pkg::OPC_BRANCH};
    endfunction

    task automatic build_program();
        int unsigned kind;
        int          t;
        logic [31:0] o;
        for (int i = 0; i < 256; i++) begin
            kind    = $urandom % 8;
            o       = 32'd4;
            prog[i] = ifu_pkg::INST_NOP;                 // half of the words
            pred[i] = 1'b0;
            err[i]  = ($urandom % 32) == 0;
            if (kind == 4 || kind == 5) begin
                t = int'($urandom % 255);
                if (t >= i) begin
                    t = t + 1;                           // never jump onto itself
                end
                o       = (t - i) * 4;
                prog[i] = jal_word(o);
                pred[i] = 1'b1;
            end else if (kind == 6 && i < 255) begin
                t       = i + 1 + int'($urandom % (255 - i));
                prog[i] = branch_word((t - i) * 4, 13'($urandom));   // forward, falls through
            end else if (kind == 7 && i > 0) begin
                t       = int'($urandom % i);
                o       = (t - i) * 4;
                prog[i] = branch_word(o, 13'($urandom));
                pred[i] = 1'b1;
            end
            step[i] = pred[i] ? o : 32'd4;
        end
    endtask

    // single-beat slave, ar and r each delayed 0 to 3 cycles
    initial begin : axi_responder
        logic        ar_hs;
        logic        r_hs;
        logic        pending;
        logic [31:0] araddr;
        logic [31:0] rd_addr;
        int unsigned ar_wait;
        int unsigned r_wait;
        m_axi_arready_i = 1'b0;
        m_axi_rvalid_i  = 1'b0;
        m_axi_rid_i     = 4'd0;                          // matches the default AXI_ID
        m_axi_rdata_i   = 32'd0;
        m_axi_rresp_i   = 2'b00;
        m_axi_rlast_i   = 1'b0;
        pending         = 1'b0;
        rd_addr         = 32'd0;
        ar_wait         = 0;
        r_wait          = 0;
        forever begin
            @(negedge clk);
            ar_hs  = m_axi_arvalid_o && m_axi_arready_i;     // transfers at next edge
            r_hs   = m_axi_rvalid_i && m_axi_rready_o;
            araddr = m_axi_araddr_o;
            if (ar_hs) begin
                check("arid", 32'd0, 32'(m_axi_arid_o));
                check("arlen", 32'd0, 32'(m_axi_arlen_o));
                check("arsize", 32'd2, 32'(m_axi_arsize_o));   // 4-byte beat
                check("arburst", 32'd1, 32'(m_axi_arburst_o)); // incr
            end
            @(posedge clk);
            #5;
            if (r_hs) begin
                m_axi_rvalid_i = 1'b0;
                pending        = 1'b0;
            end
            if (ar_hs) begin
                m_axi_arready_i = 1'b0;
                pending         = 1'b1;
                rd_addr         = araddr;
                r_wait          = $urandom % 4;
                ar_wait         = $urandom % 4;
            end else if (m_axi_arvalid_o && ar_wait == 0) begin
                m_axi_arready_i = 1'b1;
            end else if (m_axi_arvalid_o) begin
                ar_wait--;
            end
            if (pending && !m_axi_rvalid_i && r_wait == 0) begin
                m_axi_rvalid_i = 1'b1;
                m_axi_rlast_i  = 1'b1;
                m_axi_rdata_i  = prog[rd_addr[9:2]];
                m_axi_rresp_i  = err[rd_addr[9:2]] ? 2'b10 : 2'b00;
            end else if (pending && !m_axi_rvalid_i) begin
                r_wait--;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] exp_addr;                           // model: next delivered address
        logic [31:0] snap_inst;
        logic [31:0] snap_addr;
        logic        snap_valid;
        logic        hold_prev;
        int          delivered;
        int          idle;
        int unsigned hold_left;
        void'($urandom(28579));
        rst_n_i         = 1'b0;
        redirect_i      = 1'b0;
        redirect_addr_i = 32'd0;
        hold_i          = 1'b0;
        flush_i         = 1'b0;
        exp_addr        = ifu_pkg::RESET_PC;
        snap_inst       = 32'd0;
        snap_addr       = 32'd0;
        snap_valid      = 1'b0;
        hold_prev       = 1'b0;
        delivered       = 0;
        idle            = 0;
        hold_left       = 0;
        build_program();
        repeat (10) @(posedge clk);
        #5;
        rst_n_i = 1'b1;
        @(negedge clk);
        check("reset_inst_valid", 32'd0, 32'(inst_valid_o));
        check("reset_arvalid", 32'd0, 32'(m_axi_arvalid_o));
        check("reset_rready", 32'd0, 32'(m_axi_rready_o));
        check("reset_pred", 32'd0, 32'(is_pred_branch_o));
        check("reset_rd_err", 32'd0, 32'(read_resp_error_o));
        while (delivered < NUM_DELIVER) begin
            @(posedge clk);
            #5;
            redirect_i = 1'b0;
            if (hold_left > 0) begin
                hold_left--;
                hold_i = (hold_left > 0);
            end else if (delivered > 0 && $urandom % 40 == 0) begin
                redirect_i      = 1'b1;                  // one-cycle jump request
                redirect_addr_i = {22'd0, 8'($urandom), 2'b00};
            end else if (!m_axi_arvalid_o && !m_axi_rready_o && $urandom % 25 == 0) begin
                hold_left = 1 + $urandom % 6;            // only between fetches
                hold_i    = 1'b1;
            end
            @(negedge clk);
            if (hold_prev) begin                         // hold was up at the last edge
                check("hold_inst", snap_inst, inst_o);
                check("hold_addr", snap_addr, inst_addr_o);
                check("hold_valid", 32'(snap_valid), 32'(inst_valid_o));
            end
            check("hold_no_ar", 32'd0, 32'(hold_i && m_axi_arvalid_o && m_axi_arready_i));
            if (inst_valid_o && !hold_i) begin
                check("deliver_addr", exp_addr, inst_addr_o);
                check("deliver_inst", prog[exp_addr[9:2]], inst_o);
                check("predicted", 32'(pred[exp_addr[9:2]]), 32'(is_pred_branch_o));
                check("read_error", 32'(err[exp_addr[9:2]]), 32'(read_resp_error_o));
                exp_addr = exp_addr + step[exp_addr[9:2]];
                delivered++;
                idle = 0;
            end else begin
                check("no_prediction", 32'd0, 32'(is_pred_branch_o));
                idle++;
            end
            if (redirect_i) begin
                exp_addr = redirect_addr_i;              // outranks the prediction
            end
            if (idle > TIMEOUT) begin
                $display("timeout: no instruction delivered for %0d cycles", TIMEOUT);
                $display("Regression failed");
                $fatal(1);
            end
            snap_inst  = inst_o;
            snap_addr  = inst_addr_o;
            snap_valid = inst_valid_o;
            hold_prev  = hold_i;
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- ifu.f
verilog/ifu_pkg.sv
verilog/ifu_pc_gen.sv
verilog/ifu_axi_master.sv
verilog/ifu_pipe.sv
verilog/ifu_sbpu.sv
verilog/ifu.sv
test/tb_ifu.sv

//--- run.sh
#!/bin/sh
# compile and run the ifu testbench with verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f ifu.f --top-module tb_ifu -Mdir obj_dir -o sim_ifu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ifu
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
